/* hdl/ptwPkg.sv */
// Sv39 page table walker shared definitions
// widths, walker states, page types and the page table entry layout
`default_nettype none

package ptwPkg;

  ////////////////////////////////////////
  // Sv39 widths
  ////////////////////////////////////////
  localparam int xlen           = 64; // data and entry word
  localparam int paBits         = 56; // physical address
  localparam int ppnBits        = 44; // physical page number
  localparam int vpnBits        = 9;  // one vpn field per level
  localparam int pageOffsetBits = 12;
  localparam int pteBytesLog2   = 3;  // 8 byte entries

  localparam logic [3:0] svModeSv39 = 4'd8; // satp.mode for Sv39

  ////////////////////////////////////////
  // walker states and page types
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    IDLE, L2_ADR, L2_RD, L1_ADR, L1_RD, L0_ADR, L0_RD, LEAF, FAULT
  } walkStateT;

  typedef enum logic [1:0] {
    KILO = 2'd0, // 4 KiB
    MEGA = 2'd1, // 2 MiB
    GIGA = 2'd2  // 1 GiB
  } pageTypeT;

  // entry fields, msb first
  typedef struct packed {
    logic [9:0]  reserved;
    logic [25:0] ppn2;
    logic [8:0]  ppn1;
    logic [8:0]  ppn0;
    logic [1:0]  rsw;    // free for supervisor software
    logic        d, a, g, u;
    logic        x, w, r, v;
  } pteFieldsT;

  // raw word toward memory and TLB, fields for decoding
  typedef union packed {
    logic [xlen-1:0] raw;
    pteFieldsT       fields;
  } pteT;

endpackage

`default_nettype wire

/* hdl/walkStatusIf.sv */
// walk status bus
// the sequencer publishes its state and walk outcome to the result stage
`timescale 1ns/1ps
`default_nettype none

interface walkStatusIf import ptwPkg::*; ();

  walkStateT state;        // current walker state
  logic      dtlbWalk;     // walk serves the data TLB
  logic      leafReached;  // entry ready for the TLB
  logic      faultReached; // memory fault ended the walk
  logic      missPending;  // a qualified TLB miss is present

  // sequencer side drives everything
  modport seq (
    output state,
    output dtlbWalk,
    output leafReached,
    output faultReached,
    output missPending
  );

  // result side only observes
  modport res (
    input state,
    input dtlbWalk,
    input leafReached,
    input faultReached,
    input missPending
  );

endinterface

`default_nettype wire

/* hdl/pteDecode.sv */
// page table entry decoder
// flags the latched entry as valid, leaf or next level pointer
`timescale 1ns/1ps
`default_nettype none

module pteDecode import ptwPkg::*; (
  input  pteT        pte,          // latched entry
  input  logic [1:0] level,        // level the entry was read from
  output logic       pteValid,
  output logic       pteLeaf,
  output logic       pteNextLevel
);

  logic pteMisaligned; // superpage with low ppn bits set
  logic megaLowSet;
  logic gigaLowSet;

  ////////////////////////////////////////
  // permission and type bits
  ////////////////////////////////////////
  // w without r is a reserved encoding
  assign pteValid     = pte.fields.v & ~(pte.fields.w & ~pte.fields.r);
  assign pteLeaf      = pte.fields.x | pte.fields.w | pte.fields.r;
  assign pteNextLevel = pteValid & ~pteLeaf; // pointer to next table

  ////////////////////////////////////////
  // superpage alignment
  ////////////////////////////////////////
  assign megaLowSet = |pte.fields.ppn0;                      // megapage needs ppn0 clear
  assign gigaLowSet = |{pte.fields.ppn1, pte.fields.ppn0};  // gigapage needs ppn1 and ppn0 clear

  // only meaningful for leaves; the TLB raises the page fault
  always_comb begin
    case (level)
      2'd2:    pteMisaligned = pteLeaf & gigaLowSet;
      2'd1:    pteMisaligned = pteLeaf & megaLowSet;
      default: pteMisaligned = 1'b0; // kilopage is always aligned
    endcase
  end

  // checks on the decoded flags
  always_comb begin
    assert (!(pteLeaf && pteNextLevel))
      else $error("pteDecode leaf and next level pointer flagged together");
    if (pteLeaf && level == 2'd0) begin
      assert (!pteMisaligned)
        else $error("pteDecode level 0 leaf flagged misaligned");
    end
  end

endmodule

`default_nettype wire

/* hdl/walkSequencer.sv */
// Sv39 walk sequencer
// runs the walker FSM, forms each entry address and latches the returned entry
`timescale 1ns/1ps
`default_nettype none

module walkSequencer import ptwPkg::*; (
  input  logic              clk,
  input  logic              rstN,
  input  logic              flush,          // abandon walk
  input  logic [xlen-1:0]   satp,
  input  logic              itlbMiss,
  input  logic              dtlbMiss,
  input  logic [xlen-1:0]   instrVAdr,
  input  logic [xlen-1:0]   dataVAdr,
  input  logic [xlen-1:0]   memReadData,
  input  logic              memStall,
  input  logic              memAccessFault,
  input  logic              pteNextLevel,   // latched entry points further down
  output logic              memRead,
  output logic [paBits-1:0] memAdr,
  output pteT               pte,
  output logic [1:0]        level,          // level the latched entry came from
  walkStatusIf.seq          status
);

  walkStateT            state, nextState;
  logic                 dtlbWalk;    // walk is for the data side
  logic                 sv39On;
  logic                 tlbMiss;
  logic                 startWalk;
  logic                 readDone;    // read completed without fault
  logic [1:0]           stateLevel;  // table level of the current state
  logic [xlen-1:0]      vAdr;
  logic [vpnBits-1:0]   vpn;
  logic [ppnBits-1:0]   rootPpn;
  logic [ppnBits-1:0]   entryPpn;
  logic [ppnBits-1:0]   tablePpn;

  ////////////////////////////////////////
  // walk request
  ////////////////////////////////////////
  assign sv39On    = satp[xlen-1 -: 4] == svModeSv39; // walks only in Sv39
  assign tlbMiss   = (itlbMiss | dtlbMiss) & sv39On;
  assign startWalk = (state == IDLE) & tlbMiss & ~memStall;

  // data side wins when both miss
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dtlbWalk <= 1'b0;
    end else if (startWalk) begin
      dtlbWalk <= dtlbMiss;
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= IDLE;
    end else if (flush) begin
      state <= IDLE; // flush drops the walk
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state; // RD states hold while stalled
    case (state)
      IDLE:   if (startWalk) nextState = L2_ADR;
      L2_ADR: nextState = L2_RD;
      L2_RD:  if (!memStall) nextState = memAccessFault ? FAULT : L1_ADR;
      L1_ADR: nextState = pteNextLevel ? L1_RD : LEAF; // stop on leaf or bad entry
      L1_RD:  if (!memStall) nextState = memAccessFault ? FAULT : L0_ADR;
      L0_ADR: nextState = pteNextLevel ? L0_RD : LEAF;
      L0_RD:  if (!memStall) nextState = memAccessFault ? FAULT : LEAF;
      LEAF:   nextState = IDLE;
      FAULT:  nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_comb begin
    case (state)
      L2_ADR, L2_RD: stateLevel = 2'd2;
      L1_ADR, L1_RD: stateLevel = 2'd1;
      default:       stateLevel = 2'd0;
    endcase
  end

  ////////////////////////////////////////
  // entry address
  ////////////////////////////////////////
  assign vAdr     = dtlbWalk ? dataVAdr : instrVAdr;
  assign vpn      = vAdr[pageOffsetBits + vpnBits * int'(stateLevel) +: vpnBits];
  assign rootPpn  = satp[ppnBits-1:0];   // root table from satp
  assign entryPpn = {pte.fields.ppn2, pte.fields.ppn1, pte.fields.ppn0};
  assign tablePpn = (stateLevel == 2'd2) ? rootPpn : entryPpn;

  assign memAdr  = {tablePpn, vpn, {pteBytesLog2{1'b0}}};
  assign memRead = (state == L2_RD) | (state == L1_RD) | (state == L0_RD);

  ////////////////////////////////////////
  // entry register
  ////////////////////////////////////////
  assign readDone = memRead & ~memStall & ~memAccessFault;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pte   <= '0;
      level <= 2'd0;
    end else if (readDone) begin
      pte.raw <= memReadData;
      level   <= stateLevel; // remember where this entry was found
    end
  end

  // status toward the result stage
  assign status.state        = state;
  assign status.dtlbWalk     = dtlbWalk;
  assign status.leafReached  = state == LEAF;
  assign status.faultReached = state == FAULT;
  assign status.missPending  = tlbMiss;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  readOnlyInRd: assert property (@(posedge clk) disable iff (!rstN)
    memRead |-> state inside {L2_RD, L1_RD, L0_RD})
    else $error("walkSequencer memRead high in state %s", state.name());

  // stalled read keeps its address
  adrStableOnStall: assert property (@(posedge clk) disable iff (!rstN)
    (memRead && memStall && !flush) |=> $stable(memAdr))
    else $error("walkSequencer memAdr moved during a stalled read");

endmodule

`default_nettype wire

/* hdl/walkResult.sv */
// walk result stage
// tracks the page type and steers TLB write strobes and access fault pulses
`timescale 1ns/1ps
`default_nettype none

module walkResult import ptwPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     flush,
  walkStatusIf.res status,
  output pageTypeT pageType,
  output logic     itlbWrite,
  output logic     dtlbWrite,
  output logic     walkStall,
  output logic     instrAccessFault,
  output logic     dataAccessFault
);

  pageTypeT nextPageType;
  logic     walkBusy; // walker owns memory

  ////////////////////////////////////////
  // page type
  ////////////////////////////////////////
  // deepest level read so far sets the size
  always_comb begin
    case (status.state)
      L2_RD:   nextPageType = GIGA;
      L1_RD:   nextPageType = MEGA;
      L0_RD:   nextPageType = KILO;
      default: nextPageType = pageType;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pageType <= KILO;
    end else if (!flush) begin
      pageType <= nextPageType; // a flushed read leaves it alone
    end
  end

  ////////////////////////////////////////
  // strobes and pulses
  ////////////////////////////////////////
  assign itlbWrite = status.leafReached & ~status.dtlbWalk;
  assign dtlbWrite = status.leafReached & status.dtlbWalk;

  assign instrAccessFault = status.faultReached & ~status.dtlbWalk;
  assign dataAccessFault  = status.faultReached & status.dtlbWalk;

  // FAULT releases the pipeline so the trap can be taken
  assign walkBusy  = (status.state != IDLE) & (status.state != FAULT);
  assign walkStall = walkBusy | ((status.state == IDLE) & status.missPending);

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  oneTlbWrite: assert property (@(posedge clk) disable iff (!rstN)
    !(itlbWrite && dtlbWrite))
    else $error("walkResult itlbWrite and dtlbWrite high together");

endmodule

`default_nettype wire

/* hdl/pageWalker.sv */
// Sv39 hardware page table walker
// serves instruction and data TLB misses with up to three entry reads
`timescale 1ns/1ps
`default_nettype none

module pageWalker import ptwPkg::*; (
  input  logic              clk,
  input  logic              rstN,
  input  logic              flush,
  input  logic [xlen-1:0]   satp,            // mode and root page number
  input  logic              itlbMiss,
  input  logic              dtlbMiss,
  input  logic [xlen-1:0]   instrVAdr,
  input  logic [xlen-1:0]   dataVAdr,
  input  logic [xlen-1:0]   memReadData,
  input  logic              memStall,
  input  logic              memAccessFault,
  output logic              memRead,
  output logic [paBits-1:0] memAdr,
  output pteT               pte,             // entry to the TLBs
  output pageTypeT          pageType,
  output logic              itlbWrite,
  output logic              dtlbWrite,
  output logic              walkStall,
  output logic              instrAccessFault,
  output logic              dataAccessFault
);

  logic       pteNextLevel;
  logic [1:0] level;

  walkStatusIf statusBus ();

  ////////////////////////////////////////
  // FSM and address path
  ////////////////////////////////////////
  walkSequencer walkSequencer_inst (
    .clk            (clk),
    .rstN           (rstN),
    .flush          (flush),
    .satp           (satp),
    .itlbMiss       (itlbMiss),
    .dtlbMiss       (dtlbMiss),
    .instrVAdr      (instrVAdr),
    .dataVAdr       (dataVAdr),
    .memReadData    (memReadData),
    .memStall       (memStall),
    .memAccessFault (memAccessFault),
    .pteNextLevel   (pteNextLevel),
    .memRead        (memRead),
    .memAdr         (memAdr),
    .pte            (pte),
    .level          (level),
    .status         (statusBus.seq)
  );

  // entry flags back to the FSM
  pteDecode pteDecode_inst (
    .pte          (pte),
    .level        (level),
    .pteValid     (),
    .pteLeaf      (),
    .pteNextLevel (pteNextLevel)
  );

  walkResult walkResult_inst (
    .clk              (clk),
    .rstN             (rstN),
    .flush            (flush),
    .status           (statusBus.res),
    .pageType         (pageType),
    .itlbWrite        (itlbWrite),
    .dtlbWrite        (dtlbWrite),
    .walkStall        (walkStall),
    .instrAccessFault (instrAccessFault),
    .dataAccessFault  (dataAccessFault)
  );

endmodule

`default_nettype wire

/* tests/pageWalkerTb.sv */
// testbench for the Sv39 page table walker
// sparse page table memory with random stalls, directed walks, assertion checks
`timescale 1ns/1ps
`default_nettype none

module pageWalkerTb import ptwPkg::*; ();

  localparam int clkPeriod     = 8;
  localparam int walkCount     = 10; // walks started by the stimulus
  localparam int cyclesPerWalk = 40; // generous bound incl. stalls
  localparam int endWrite      = 0;
  localparam int endFault      = 1;
  localparam int endNone       = 2;

  logic clk, rstN, flush, itlbMiss, dtlbMiss, memStall, memAccessFault;
  logic [63:0] satp, instrVAdr, dataVAdr, memReadData;
  logic memRead, itlbWrite, dtlbWrite, walkStall, instrAccessFault, dataAccessFault;
  logic [paBits-1:0] memAdr;
  pteT      pte;
  pageTypeT pageType;

  logic [63:0] pageMem [logic [55:0]]; // sparse page table memory
  bit          faultMap [logic [55:0]]; // addresses that fault
  int          tableGen;                 // bumped on every table edit
  logic [1:0]  stallLeft;                // stall cycles left for this read
  logic [1:0]  readIdx;                  // completed reads in this walk
  logic [55:0] heldAdr;                  // memAdr of the previous cycle

  // expectations for the walk in flight
  logic [55:0] expAdr [4];
  logic [1:0]  expReads;
  logic [63:0] expPte;
  pageTypeT    expPageType;
  logic        expDtlb;
  int          expEnd;
  logic [43:0] walkRoot;
  int          errCount;
  int          walksDone;

  pageWalker pageWalker_inst (
    .clk(clk), .rstN(rstN), .flush(flush), .satp(satp),
    .itlbMiss(itlbMiss), .dtlbMiss(dtlbMiss),
    .instrVAdr(instrVAdr), .dataVAdr(dataVAdr),
    .memReadData(memReadData), .memStall(memStall), .memAccessFault(memAccessFault),
    .memRead(memRead), .memAdr(memAdr), .pte(pte), .pageType(pageType),
    .itlbWrite(itlbWrite), .dtlbWrite(dtlbWrite), .walkStall(walkStall),
    .instrAccessFault(instrAccessFault), .dataAccessFault(dataAccessFault)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // table helpers
  ////////////////////////////////////////
  function automatic logic [8:0] vpnOf(input logic [63:0] va, input logic [1:0] lvl);
    return 9'((va >> (12 + 9 * int'(lvl))) & 64'h1ff); // 9 bit field above the offset
  endfunction

  function automatic logic [55:0] entryAdr(input logic [43:0] ppn, input logic [8:0] vpn);
    return 56'(ppn) * 56'd4096 + 56'(vpn) * 56'd8;
  endfunction

  function automatic logic [63:0] makePte(input logic [43:0] ppn, input logic [7:0] flags);
    return {10'd0, ppn, 2'b00, flags};
  endfunction

  // gen only makes the lookup follow table edits
  function automatic logic [63:0] readEntry(input logic [55:0] adr, input int gen);
    if (pageMem.exists(adr)) return pageMem[adr];
    return 64'd0;
  endfunction

  function automatic logic faultsAt(input logic [55:0] adr, input int gen);
    return faultMap.exists(adr) != 0;
  endfunction

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////
  assign memReadData    = readEntry(memAdr, tableGen); // same cycle answer
  assign memAccessFault = memRead && faultsAt(memAdr, tableGen);
  assign memStall       = memRead && (stallLeft != 2'd0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stallLeft <= 2'd0;
      readIdx   <= 2'd0;
      heldAdr   <= '0;
    end else begin
      heldAdr <= memAdr;
      if (memRead && stallLeft != 2'd0) stallLeft <= stallLeft - 2'd1;
      else if (memRead) stallLeft <= 2'($urandom_range(3, 0)); // next read
      if (itlbWrite || dtlbWrite || instrAccessFault || dataAccessFault || flush)
        readIdx <= 2'd0;
      else if (memRead && !memStall) readIdx <= readIdx + 2'd1;
    end
  end

  task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                input logic [63:0] actVal);
    errCount++;
    $display("[ERROR] t=%0t %s expected %h got %h", $time, name, expVal, actVal);
  endtask

  task automatic reportFailure(input string what);
    errCount++;
    $display("t=%0t %s", $time, what);
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  adrMatch: assert property (@(posedge clk) disable iff (!rstN)
    (memRead && !memStall) |-> memAdr == expAdr[readIdx])
    else reportMismatch("memAdr", 64'(expAdr[$sampled(readIdx)]), 64'($sampled(memAdr)));

  adrHeld: assert property (@(posedge clk) disable iff (!rstN)
    (memRead && memStall && !flush) |=> memAdr == heldAdr)
    else reportMismatch("memAdr", 64'($sampled(heldAdr)), 64'($sampled(memAdr)));

  writeExpected: assert property (@(posedge clk) disable iff (!rstN)
    (itlbWrite || dtlbWrite) |-> expEnd == endWrite)
    else reportFailure("TLB write strobe where the walk should not write the TLB");

  faultExpected: assert property (@(posedge clk) disable iff (!rstN)
    (instrAccessFault || dataAccessFault) |-> expEnd == endFault)
    else reportFailure("access fault pulse where the walk should not fault");

  // a walk ends with a single cycle strobe
  endIsPulse: assert property (@(posedge clk) disable iff (!rstN)
    (itlbWrite || dtlbWrite || instrAccessFault || dataAccessFault)
      |=> !(itlbWrite || dtlbWrite || instrAccessFault || dataAccessFault))
    else reportFailure("TLB write or access fault held for more than one cycle");

  writeSide: assert property (@(posedge clk) disable iff (!rstN)
    (itlbWrite || dtlbWrite) |-> dtlbWrite == expDtlb)
    else reportMismatch("dtlbWrite", 64'(expDtlb), 64'($sampled(dtlbWrite)));

  writeEntry: assert property (@(posedge clk) disable iff (!rstN)
    (itlbWrite || dtlbWrite) |-> pte.raw == expPte)
    else reportMismatch("pte", expPte, $sampled(pte.raw));

  writePageType: assert property (@(posedge clk) disable iff (!rstN)
    (itlbWrite || dtlbWrite) |-> pageType == expPageType)
    else reportMismatch("pageType", 64'(expPageType), 64'($sampled(pageType)));

  writeReadCount: assert property (@(posedge clk) disable iff (!rstN)
    (itlbWrite || dtlbWrite) |-> readIdx == expReads)
    else reportMismatch("read count", 64'(expReads), 64'($sampled(readIdx)));

  faultSide: assert property (@(posedge clk) disable iff (!rstN)
    (instrAccessFault || dataAccessFault) |-> dataAccessFault == expDtlb)
    else reportMismatch("dataAccessFault", 64'(expDtlb), 64'($sampled(dataAccessFault)));

  // trap must be able to proceed
  faultReleases: assert property (@(posedge clk) disable iff (!rstN)
    (instrAccessFault || dataAccessFault) |-> !walkStall && !itlbWrite && !dtlbWrite)
    else reportFailure("walkStall or a TLB write high during an access fault");

  flushIdles: assert property (@(posedge clk) disable iff (!rstN)
    flush |=> !memRead && !itlbWrite && !dtlbWrite)
    else reportFailure("walker still reading or writing the cycle after flush");

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  // chain of pointers down to the entry that ends the walk
  task automatic planWalk(input logic [63:0] va, input logic [43:0] root,
                          input logic [1:0] depth, input logic [43:0] lastPpn,
                          input logic [7:0] lastFlags);
    logic [43:0] ppn;
    logic [55:0] adr;
    logic [1:0]  i;
    ppn      = root;
    walkRoot = root;
    for (i = 2'd0; i < depth; i = i + 2'd1) begin
      adr       = entryAdr(ppn, vpnOf(va, 2'd2 - i));
      expAdr[i] = adr;
      if (i == depth - 2'd1) begin
        pageMem[adr] = makePte(lastPpn, lastFlags);
        expPte       = makePte(lastPpn, lastFlags);
      end else begin
        ppn          = ppn + 44'h10; // next table 16 pages up
        pageMem[adr] = makePte(ppn, 8'h01);
      end
    end
    expReads    = depth;
    expPageType = (depth == 2'd1) ? GIGA : (depth == 2'd2) ? MEGA : KILO;
    tableGen++;
  endtask

  task automatic markFault(input logic [55:0] adr);
    faultMap[adr] = 1'b1;
    tableGen++;
  endtask

  // raise the misses, wait for the end strobe, idle one cycle
  task automatic runWalk(input logic iMiss, input logic dMiss, input logic [63:0] iVa,
                         input logic [63:0] dVa, input int endKind);
    expDtlb = dMiss;
    expEnd  = endKind;
    satp      <= {svModeSv39, 16'd0, walkRoot};
    instrVAdr <= iVa;
    dataVAdr  <= dVa;
    itlbMiss  <= iMiss;
    dtlbMiss  <= dMiss;
    do begin
      @(posedge clk);
    end while (!(itlbWrite || dtlbWrite || instrAccessFault || dataAccessFault));
    itlbMiss <= 1'b0;
    dtlbMiss <= 1'b0;
    @(posedge clk);
    walksDone++;
  endtask

  task automatic flushWalk(input logic [63:0] va);
    expDtlb = 1'b1;
    expEnd  = endNone;
    satp     <= {svModeSv39, 16'd0, walkRoot};
    dataVAdr <= va;
    dtlbMiss <= 1'b1;
    do begin
      @(posedge clk);
    end while (!memRead);
    flush    <= 1'b1; // abandon the first level read
    dtlbMiss <= 1'b0;
    @(posedge clk);
    flush <= 1'b0;
    repeat (3) @(posedge clk);
    walksDone++;
  endtask

  initial begin
    logic [63:0] rndVa;
    void'($urandom(32'hd06));
    rstN        = 1'b0;
    flush       = 1'b0;
    itlbMiss    = 1'b0;
    dtlbMiss    = 1'b0;
    satp        = '0;
    instrVAdr   = '0;
    dataVAdr    = '0;
    errCount    = 0;
    walksDone   = 0;
    tableGen    = 0;
    expEnd      = endNone;
    expDtlb     = 1'b0;
    expReads    = 2'd0;
    expPte      = '0;
    expPageType = KILO;
    walkRoot    = '0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);

    planWalk(64'h0000_0040_2345_6000, 44'h80000, 2'd3, 44'h00abcde, 8'hcf); // kilopage
    runWalk(1'b0, 1'b1, 64'h0, 64'h0000_0040_2345_6000, endWrite);
    planWalk(64'h0000_0012_8000_1000, 44'h80100, 2'd1, 44'h0040000, 8'hcb); // gigapage
    runWalk(1'b1, 1'b0, 64'h0000_0012_8000_1000, 64'h0, endWrite);
    planWalk(64'h0000_0055_4321_0000, 44'h80200, 2'd2, 44'h0001200, 8'hc3); // megapage
    runWalk(1'b1, 1'b0, 64'h0000_0055_4321_0000, 64'h0, endWrite);

    // entries that are neither leaf nor pointer
    planWalk(64'h0000_0033_1234_5000, 44'h80300, 2'd1, 44'h0001111, 8'h00);
    runWalk(1'b0, 1'b1, 64'h0, 64'h0000_0033_1234_5000, endWrite);
    planWalk(64'h0000_0021_fedc_b000, 44'h80400, 2'd1, 44'h0002222, 8'h05);
    runWalk(1'b1, 1'b0, 64'h0000_0021_fedc_b000, 64'h0, endWrite);

    planWalk(64'h0000_0077_0bad_0000, 44'h80500, 2'd3, 44'h0003333, 8'hcf);
    markFault(expAdr[1]); // fault on the level 1 read
    runWalk(1'b0, 1'b1, 64'h0, 64'h0000_0077_0bad_0000, endFault);
    planWalk(64'h0000_0009_8765_4000, 44'h80600, 2'd1, 44'h0040000, 8'hcb);
    markFault(expAdr[0]);
    runWalk(1'b1, 1'b0, 64'h0000_0009_8765_4000, 64'h0, endFault);

    // both TLBs miss, data side must win
    planWalk(64'h0000_0066_abcd_e000, 44'h80700, 2'd3, 44'h0004444, 8'hcf);
    runWalk(1'b1, 1'b1, 64'h0000_0011_1111_1000, 64'h0000_0066_abcd_e000, endWrite);
    rndVa = {$urandom, $urandom};
    planWalk(rndVa, 44'h80800, 2'd3, 44'h0005555, 8'hcf);
    runWalk(1'b0, 1'b1, 64'h0, rndVa, endWrite);

    planWalk(64'h0000_0044_5566_7000, 44'h80900, 2'd3, 44'h0006666, 8'hcf);
    flushWalk(64'h0000_0044_5566_7000);

    repeat (2) @(posedge clk);
    $display("pageWalkerTb: %0d walks, %0d errors", walksDone, errCount);
    if (errCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog sized from the walk count
  initial begin
    #(walkCount * cyclesPerWalk * clkPeriod);
    $display("watchdog expired after %0d walks, a walk never finished", walksDone);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
hdl/ptwPkg.sv
hdl/walkStatusIf.sv
hdl/pteDecode.sv
hdl/walkSequencer.sv
hdl/walkResult.sv
hdl/pageWalker.sv
tests/pageWalkerTb.sv

/* Makefile */
# Verilator build and run of the Sv39 page table walker testbench

TOP   = pageWalkerTb
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing --top-module $(TOP) -f filelist.f --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
